//--- hdl/rs_pkg.sv
package rs_pkg;

    // ======================================================================
    // Default sizes, overridden through the top-level parameters
    // ======================================================================
    parameter int unsigned RS_DEPTH       = 8;
    parameter int unsigned DISPATCH_WIDTH = 2;
    parameter int unsigned CDB_WIDTH      = 2;
    parameter int unsigned PHYS_REGS      = 32;

    parameter int unsigned TAG_W = $clog2(PHYS_REGS);

    // Physical register tag
    typedef logic [TAG_W-1:0] tag_t;

    // Integer opcodes seen by the station
    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLL  = 3'd5,
        OP_MUL  = 3'd6,
        OP_MULH = 3'd7
    } opcode_e;

    // Functional unit classes
    typedef enum logic {
        FU_ALU = 1'b0,
        FU_MUL = 1'b1
    } fu_type_e;

    // One station slot, tags only
    typedef struct packed {
        opcode_e opcode;
        tag_t    dst_tag;
        tag_t    src1_tag;
        logic    src1_rdy;
        tag_t    src2_tag;
        logic    src2_rdy;
    } rs_entry_t;

    // Multiplies go to the MUL unit, everything else to the ALU
    function automatic fu_type_e fu_of_opcode(input opcode_e op);
        return (op == OP_MUL || op == OP_MULH) ? FU_MUL : FU_ALU;
    endfunction

endpackage

//--- hdl/rs_view_if.sv
`timescale 1ns/1ps

interface rs_view_if #(
    parameter int unsigned RS_DEPTH = rs_pkg::RS_DEPTH
);

    // Station contents, one slot per bit or element
    rs_pkg::rs_entry_t [RS_DEPTH-1:0] entries;
    logic              [RS_DEPTH-1:0] ready;
    rs_pkg::fu_type_e  [RS_DEPTH-1:0] fu_type;

    // Issue enables going back to the station
    logic              [RS_DEPTH-1:0] issue_en;

    // Station side owns the state
    modport station (
        output entries,
        output ready,
        output fu_type,
        input  issue_en
    );

    // Selectors only need readiness and unit class
    modport selector (
        input ready,
        input fu_type
    );

    // Merge reads payload, returns enables
    modport merger (
        input  entries,
        output issue_en
    );

endinterface

//--- hdl/rs_single_entry.sv
`timescale 1ns/1ps

module rs_single_entry #(
    parameter int unsigned PHYS_REGS = rs_pkg::PHYS_REGS,
    parameter int unsigned CDB_WIDTH = rs_pkg::CDB_WIDTH
) (
    input  logic                                clk,
    input  logic                                rst_n_i,
    input  logic                                flush_i,
    input  logic                                disp_en_i,
    input  rs_pkg::rs_entry_t                   packet_i,
    input  logic                                issue_i,
    input  logic              [CDB_WIDTH-1:0]   cdb_valid_i,
    input  rs_pkg::tag_t      [CDB_WIDTH-1:0]   cdb_tag_i,
    output logic                                empty_o,
    output rs_pkg::rs_entry_t                   entry_o,
    output rs_pkg::fu_type_e                    fu_type_o,
    output logic                                ready_o
);

    localparam int unsigned TAG_W = $clog2(PHYS_REGS);

    logic              valid_q;
    rs_pkg::rs_entry_t entry_q;

    // Tag matches against the CDB lanes
    logic pkt_src1_hit;
    logic pkt_src2_hit;
    logic ent_src1_hit;
    logic ent_src2_hit;

    // Any valid CDB lane carrying this tag
    function automatic logic cdb_hit(
        input rs_pkg::tag_t                  tag,
        input logic         [CDB_WIDTH-1:0]  vld,
        input rs_pkg::tag_t [CDB_WIDTH-1:0]  tags
    );
        logic hit;
        hit = 1'b0;
        for (int k = 0; k < CDB_WIDTH; k++) begin
            if (vld[k] && (tags[k][TAG_W-1:0] == tag[TAG_W-1:0]))
                hit = 1'b1;
        end
        return hit;
    endfunction

    // Bypass for a packet arriving with its producer on the CDB
    assign pkt_src1_hit = cdb_hit(packet_i.src1_tag, cdb_valid_i, cdb_tag_i);
    assign pkt_src2_hit = cdb_hit(packet_i.src2_tag, cdb_valid_i, cdb_tag_i);
    // Wakeup for the stored sources
    assign ent_src1_hit = cdb_hit(entry_q.src1_tag, cdb_valid_i, cdb_tag_i);
    assign ent_src2_hit = cdb_hit(entry_q.src2_tag, cdb_valid_i, cdb_tag_i);

    // Occupancy, flush wins over a same-cycle dispatch
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i)
            valid_q <= 1'b0;
        else if (flush_i)
            valid_q <= 1'b0;
        else if (disp_en_i)
            valid_q <= 1'b1;
        else if (issue_i)
            valid_q <= 1'b0;
    end

    // Payload and source ready bits
    always_ff @(posedge clk) begin
        if (disp_en_i) begin
            entry_q          <= packet_i;
            entry_q.src1_rdy <= packet_i.src1_rdy | pkt_src1_hit;
            entry_q.src2_rdy <= packet_i.src2_rdy | pkt_src2_hit;
        end else begin
            entry_q.src1_rdy <= entry_q.src1_rdy | ent_src1_hit;
            entry_q.src2_rdy <= entry_q.src2_rdy | ent_src2_hit;
        end
    end

    assign empty_o   = ~valid_q;
    assign entry_o   = entry_q;
    assign fu_type_o = rs_pkg::fu_of_opcode(entry_q.opcode);
    // Both operands present
    assign ready_o   = valid_q & entry_q.src1_rdy & entry_q.src2_rdy;

endmodule

//--- hdl/disp_selector.sv
`timescale 1ns/1ps

module disp_selector #(
    parameter int unsigned RS_DEPTH       = rs_pkg::RS_DEPTH,
    parameter int unsigned DISPATCH_WIDTH = rs_pkg::DISPATCH_WIDTH
) (
    input  logic [RS_DEPTH-1:0]                     empty_i,
    input  logic [DISPATCH_WIDTH-1:0]               disp_valid_i,
    output logic [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] grant_o
);

    // Slots still up for grabs while walking the lanes
    logic [RS_DEPTH-1:0] avail;
    logic                found;

    always_comb begin
        avail   = empty_i;
        grant_o = '0;
        found   = 1'b0;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            found = 1'b0;
            // Lowest free slot for this lane
            if (disp_valid_i[l]) begin
                for (int j = 0; j < RS_DEPTH; j++) begin
                    if (avail[j] && !found) begin
                        grant_o[l][j] = 1'b1;
                        found         = 1'b1;
                    end
                end
            end
            // Hide it from higher lanes
            avail = avail & ~grant_o[l];
        end
    end

endmodule

//--- hdl/rs.sv
`timescale 1ns/1ps

module rs #(
    parameter int unsigned RS_DEPTH       = rs_pkg::RS_DEPTH,
    parameter int unsigned DISPATCH_WIDTH = rs_pkg::DISPATCH_WIDTH,
    parameter int unsigned CDB_WIDTH      = rs_pkg::CDB_WIDTH,
    parameter int unsigned PHYS_REGS      = rs_pkg::PHYS_REGS
) (
    input  logic                                             clk,
    input  logic                                             rst_n_i,
    input  logic                                             flush_i,

    // ======================================================================
    // Dispatch
    // ======================================================================
    input  logic              [DISPATCH_WIDTH-1:0]           disp_valid_i,
    input  rs_pkg::rs_entry_t [DISPATCH_WIDTH-1:0]           packets_i,

    // ======================================================================
    // CDB wakeup
    // ======================================================================
    input  logic              [CDB_WIDTH-1:0]                cdb_valid_i,
    input  rs_pkg::tag_t      [CDB_WIDTH-1:0]                cdb_tag_i,

    // Occupancy back to dispatch
    output logic              [$clog2(DISPATCH_WIDTH+1)-1:0] free_slots_o,
    output logic                                             rs_full_o,

    rs_view_if.station                                       view
);

    localparam int unsigned FREE_W = $clog2(DISPATCH_WIDTH + 1);
    localparam logic [FREE_W-1:0] FREE_MAX = FREE_W'(DISPATCH_WIDTH);

    logic              [RS_DEPTH-1:0]                 disp_en;
    rs_pkg::rs_entry_t [RS_DEPTH-1:0]                 slot_pkt;
    logic              [RS_DEPTH-1:0]                 empty;
    logic              [DISPATCH_WIDTH-1:0][RS_DEPTH-1:0] disp_grant;
    logic              [FREE_W-1:0]                   free_cnt;

    // ======================================================================
    // Entry array
    // ======================================================================
    for (genvar i = 0; i < RS_DEPTH; i++) begin : g_entry
        rs_single_entry #(
            .PHYS_REGS (PHYS_REGS),
            .CDB_WIDTH (CDB_WIDTH)
        ) u_entry (
            .clk         (clk),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .disp_en_i   (disp_en[i]),
            .packet_i    (slot_pkt[i]),
            .issue_i     (view.issue_en[i]),
            .cdb_valid_i (cdb_valid_i),
            .cdb_tag_i   (cdb_tag_i),
            .empty_o     (empty[i]),
            .entry_o     (view.entries[i]),
            .fu_type_o   (view.fu_type[i]),
            .ready_o     (view.ready[i])
        );
    end

    // Slot allocation per lane
    disp_selector #(
        .RS_DEPTH       (RS_DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH)
    ) u_disp_sel (
        .empty_i      (empty),
        .disp_valid_i (disp_valid_i),
        .grant_o      (disp_grant)
    );

    // Steer each granted lane's packet to its slot
    always_comb begin
        slot_pkt = '0;
        disp_en  = '0;
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            for (int j = 0; j < RS_DEPTH; j++) begin
                if (disp_grant[l][j]) begin
                    slot_pkt[j] = packets_i[l];
                    disp_en[j]  = 1'b1;
                end
            end
        end
    end

    // ======================================================================
    // Free slot count, capped at the dispatch width
    // ======================================================================
    always_comb begin
        free_cnt = '0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (empty[j] && (free_cnt < FREE_MAX))
                free_cnt = free_cnt + FREE_W'(1);
        end
    end

    assign free_slots_o = free_cnt;
    assign rs_full_o    = ~|empty;

endmodule

//--- hdl/fu_issue_select.sv
`timescale 1ns/1ps

module fu_issue_select #(
    parameter int unsigned      RS_DEPTH = rs_pkg::RS_DEPTH,
    parameter rs_pkg::fu_type_e FU_SEL   = rs_pkg::FU_ALU
) (
    rs_view_if.selector         view,
    output logic [RS_DEPTH-1:0] grant_o,
    output logic                found_o
);

    // Ready slots of our unit class
    logic [RS_DEPTH-1:0] cand;

    always_comb begin
        for (int j = 0; j < RS_DEPTH; j++)
            cand[j] = view.ready[j] && (view.fu_type[j] == FU_SEL);
    end

    // Isolate lowest set bit, lowest index wins
    assign grant_o = cand & (~cand + RS_DEPTH'(1));
    assign found_o = |cand;

endmodule

//--- hdl/issue_merge.sv
`timescale 1ns/1ps

module issue_merge #(
    parameter int unsigned RS_DEPTH = rs_pkg::RS_DEPTH
) (
    rs_view_if.merger                 view,
    input  logic      [RS_DEPTH-1:0]  alu_grant_i,
    input  logic                      alu_found_i,
    input  logic      [RS_DEPTH-1:0]  mul_grant_i,
    input  logic                      mul_found_i,
    output logic                      alu_valid_o,
    output rs_pkg::opcode_e           alu_opcode_o,
    output rs_pkg::tag_t              alu_dst_o,
    output logic                      mul_valid_o,
    output rs_pkg::opcode_e           mul_opcode_o,
    output rs_pkg::tag_t              mul_dst_o
);

    rs_pkg::rs_entry_t alu_sel;
    rs_pkg::rs_entry_t mul_sel;

    // Grants are disjoint, release both slots together
    assign view.issue_en = alu_grant_i | mul_grant_i;

    // One-hot muxes onto the two ports
    always_comb begin
        alu_sel = '0;
        mul_sel = '0;
        for (int j = 0; j < RS_DEPTH; j++) begin
            if (alu_grant_i[j])
                alu_sel = view.entries[j];
            if (mul_grant_i[j])
                mul_sel = view.entries[j];
        end
    end

    assign alu_valid_o  = alu_found_i;
    assign alu_opcode_o = alu_sel.opcode;
    assign alu_dst_o    = alu_sel.dst_tag;
    assign mul_valid_o  = mul_found_i;
    assign mul_opcode_o = mul_sel.opcode;
    assign mul_dst_o    = mul_sel.dst_tag;

endmodule

//--- hdl/rs_issue_top.sv
`timescale 1ns/1ps

module rs_issue_top #(
    parameter int unsigned RS_DEPTH       = rs_pkg::RS_DEPTH,
    parameter int unsigned DISPATCH_WIDTH = rs_pkg::DISPATCH_WIDTH,
    parameter int unsigned CDB_WIDTH      = rs_pkg::CDB_WIDTH,
    parameter int unsigned PHYS_REGS      = rs_pkg::PHYS_REGS
) (
    input  logic                                           clk,
    input  logic                                           rst_n_i,
    input  logic                                           flush_i,
    // Dispatch lanes
    input  logic            [DISPATCH_WIDTH-1:0]           disp_valid_i,
    input  rs_pkg::opcode_e [DISPATCH_WIDTH-1:0]           disp_opcode_i,
    input  rs_pkg::tag_t    [DISPATCH_WIDTH-1:0]           disp_dst_i,
    input  rs_pkg::tag_t    [DISPATCH_WIDTH-1:0]           disp_src1_i,
    input  logic            [DISPATCH_WIDTH-1:0]           disp_src1_rdy_i,
    input  rs_pkg::tag_t    [DISPATCH_WIDTH-1:0]           disp_src2_i,
    input  logic            [DISPATCH_WIDTH-1:0]           disp_src2_rdy_i,
    // CDB broadcast
    input  logic            [CDB_WIDTH-1:0]                cdb_valid_i,
    input  rs_pkg::tag_t    [CDB_WIDTH-1:0]                cdb_tag_i,
    output logic            [$clog2(DISPATCH_WIDTH+1)-1:0] free_slots_o,
    output logic                                           rs_full_o,
    // Issue ports
    output logic                                           alu_issue_valid_o,
    output rs_pkg::opcode_e                                alu_issue_opcode_o,
    output rs_pkg::tag_t                                   alu_issue_dst_o,
    output logic                                           mul_issue_valid_o,
    output rs_pkg::opcode_e                                mul_issue_opcode_o,
    output rs_pkg::tag_t                                   mul_issue_dst_o
);

    rs_pkg::rs_entry_t [DISPATCH_WIDTH-1:0] packets;
    logic              [RS_DEPTH-1:0]       alu_grant;
    logic              [RS_DEPTH-1:0]       mul_grant;
    logic                                   alu_found;
    logic                                   mul_found;

    rs_view_if #(.RS_DEPTH(RS_DEPTH)) view_if ();

    // Bundle the lane fields into entry packets
    always_comb begin
        for (int l = 0; l < DISPATCH_WIDTH; l++) begin
            packets[l].opcode   = disp_opcode_i[l];
            packets[l].dst_tag  = disp_dst_i[l];
            packets[l].src1_tag = disp_src1_i[l];
            packets[l].src1_rdy = disp_src1_rdy_i[l];
            packets[l].src2_tag = disp_src2_i[l];
            packets[l].src2_rdy = disp_src2_rdy_i[l];
        end
    end

    // ======================================================================
    // Station, selectors and merge
    // ======================================================================
    rs #(
        .RS_DEPTH       (RS_DEPTH),
        .DISPATCH_WIDTH (DISPATCH_WIDTH),
        .CDB_WIDTH      (CDB_WIDTH),
        .PHYS_REGS      (PHYS_REGS)
    ) u_rs (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .packets_i    (packets),
        .cdb_valid_i  (cdb_valid_i),
        .cdb_tag_i    (cdb_tag_i),
        .free_slots_o (free_slots_o),
        .rs_full_o    (rs_full_o),
        .view         (view_if.station)
    );

    fu_issue_select #(
        .RS_DEPTH (RS_DEPTH),
        .FU_SEL   (rs_pkg::FU_ALU)
    ) u_alu_sel (
        .view    (view_if.selector),
        .grant_o (alu_grant),
        .found_o (alu_found)
    );

    fu_issue_select #(
        .RS_DEPTH (RS_DEPTH),
        .FU_SEL   (rs_pkg::FU_MUL)
    ) u_mul_sel (
        .view    (view_if.selector),
        .grant_o (mul_grant),
        .found_o (mul_found)
    );

    issue_merge #(
        .RS_DEPTH (RS_DEPTH)
    ) u_merge (
        .view         (view_if.merger),
        .alu_grant_i  (alu_grant),
        .alu_found_i  (alu_found),
        .mul_grant_i  (mul_grant),
        .mul_found_i  (mul_found),
        .alu_valid_o  (alu_issue_valid_o),
        .alu_opcode_o (alu_issue_opcode_o),
        .alu_dst_o    (alu_issue_dst_o),
        .mul_valid_o  (mul_issue_valid_o),
        .mul_opcode_o (mul_issue_opcode_o),
        .mul_dst_o    (mul_issue_dst_o)
    );

endmodule

//--- verification/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD     = 40,
    parameter int RST_CYCLES = 4
) (
    output logic clk_o,
    output logic rst_n_o
);

    // Free-running clock
    initial clk_o = 1'b0;
    always #(PERIOD / 2) clk_o = ~clk_o;

    // Reset held low for a few edges, released on a rising edge
    initial begin
        rst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        rst_n_o <= 1'b1;
    end

endmodule

//--- verification/rs_issue_sva.sv
`timescale 1ns/1ps

module rs_issue_sva (
    input logic            clk,
    input logic            rst_n_i,
    input logic            flush_i,
    input logic [1:0]      free_slots_o,
    input logic            rs_full_o,
    input logic            alu_issue_valid_o,
    input rs_pkg::opcode_e alu_issue_opcode_o,
    input logic            mul_issue_valid_o,
    input rs_pkg::opcode_e mul_issue_opcode_o
);

    // Station is empty right after a flush edge
    a_flush_quiet: assert property (@(posedge clk) disable iff (!rst_n_i)
        flush_i |=> (!alu_issue_valid_o && !mul_issue_valid_o))
        else $error("issue valid after flush");

    // Full flag tracks a zero free count
    a_full_free: assert property (@(posedge clk) disable iff (!rst_n_i)
        rs_full_o == (free_slots_o == 2'd0))
        else $error("full flag and free count disagree");

    // Port routing by unit class
    a_alu_class: assert property (@(posedge clk) disable iff (!rst_n_i)
        alu_issue_valid_o |-> (rs_pkg::fu_of_opcode(alu_issue_opcode_o) == rs_pkg::FU_ALU))
        else $error("multiply opcode on ALU port");
    a_mul_class: assert property (@(posedge clk) disable iff (!rst_n_i)
        mul_issue_valid_o |-> (rs_pkg::fu_of_opcode(mul_issue_opcode_o) == rs_pkg::FU_MUL))
        else $error("non-multiply opcode on MUL port");

    // Nothing issues while in reset
    a_reset_quiet: assert property (@(posedge clk)
        !rst_n_i |-> (!alu_issue_valid_o && !mul_issue_valid_o))
        else $error("issue valid during reset");

endmodule

bind rs_issue_top rs_issue_sva sva_i (
    .clk                (clk),
    .rst_n_i            (rst_n_i),
    .flush_i            (flush_i),
    .free_slots_o       (free_slots_o),
    .rs_full_o          (rs_full_o),
    .alu_issue_valid_o  (alu_issue_valid_o),
    .alu_issue_opcode_o (alu_issue_opcode_o),
    .mul_issue_valid_o  (mul_issue_valid_o),
    .mul_issue_opcode_o (mul_issue_opcode_o)
);

//--- verification/rs_issue_tb.sv
`timescale 1ns/1ps

module rs_issue_tb;

    localparam int DEPTH      = 8;
    localparam int MAX_CYCLES = 2000;

    logic                      clk;
    logic                      rst_n;
    logic                      flush;
    logic [1:0]                disp_valid;
    rs_pkg::opcode_e [1:0]     disp_opcode;
    rs_pkg::tag_t    [1:0]     disp_dst;
    rs_pkg::tag_t    [1:0]     disp_src1;
    rs_pkg::tag_t    [1:0]     disp_src2;
    logic [1:0]                disp_src1_rdy;
    logic [1:0]                disp_src2_rdy;
    logic [1:0]                cdb_valid;
    rs_pkg::tag_t    [1:0]     cdb_tag;
    logic [1:0]                free_slots;
    logic                      rs_full;
    logic                      alu_valid;
    rs_pkg::opcode_e           alu_opcode;
    rs_pkg::tag_t              alu_dst;
    logic                      mul_valid;
    rs_pkg::opcode_e           mul_opcode;
    rs_pkg::tag_t              mul_dst;

    // Model of the station contents
    logic [DEPTH-1:0]          m_valid;
    rs_pkg::rs_entry_t         m_entry [DEPTH];
    int                        model_free;
    int                        err_cnt;
    int                        test_cnt;
    int                        cycle_cnt;

    tb_clkgen #(.PERIOD(40), .RST_CYCLES(4)) clkgen_i (.clk_o(clk), .rst_n_o(rst_n));

    rs_issue_top #(
        .RS_DEPTH(DEPTH), .DISPATCH_WIDTH(2), .CDB_WIDTH(2), .PHYS_REGS(32)
    ) dut_i (
        .clk(clk), .rst_n_i(rst_n), .flush_i(flush),
        .disp_valid_i(disp_valid), .disp_opcode_i(disp_opcode), .disp_dst_i(disp_dst),
        .disp_src1_i(disp_src1), .disp_src1_rdy_i(disp_src1_rdy),
        .disp_src2_i(disp_src2), .disp_src2_rdy_i(disp_src2_rdy),
        .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag),
        .free_slots_o(free_slots), .rs_full_o(rs_full),
        .alu_issue_valid_o(alu_valid), .alu_issue_opcode_o(alu_opcode),
        .alu_issue_dst_o(alu_dst), .mul_issue_valid_o(mul_valid),
        .mul_issue_opcode_o(mul_opcode), .mul_issue_dst_o(mul_dst)
    );

    // ======================================================================
    // Reference model
    // ======================================================================
    // Lowest ready entry of one unit class or -1
    function automatic int pick_entry(input rs_pkg::fu_type_e fu);
        for (int j = 0; j < DEPTH; j++) begin
            if (m_valid[j] && m_entry[j].src1_rdy && m_entry[j].src2_rdy &&
                rs_pkg::fu_of_opcode(m_entry[j].opcode) == fu)
                return j;
        end
        return -1;
    endfunction

    function automatic logic cdb_match(input rs_pkg::tag_t tag);
        return (cdb_valid[0] && cdb_tag[0] == tag) || (cdb_valid[1] && cdb_tag[1] == tag);
    endfunction

    // Empty slots capped at two lanes
    function automatic int count_free();
        int n;
        n = 0;
        for (int j = 0; j < DEPTH; j++)
            if (!m_valid[j] && n < 2)
                n++;
        return n;
    endfunction

    task automatic check_val(input string name, input int exp, input int act);
        if (exp != act) begin
            $display("mismatch at %0t: %s expected %0h got %0h", $time, name, exp, act);
            err_cnt++;
        end
    endtask

    // Compare mid-cycle and advance the model across the next edge
    always @(negedge clk) begin
        int               a_idx;
        int               m_idx;
        int               slot;
        logic [DEPTH-1:0] empty;
        if (rst_n !== 1'b1) begin
            m_valid    = '0;
            model_free = 2;
        end else begin
            a_idx = pick_entry(rs_pkg::FU_ALU);
            m_idx = pick_entry(rs_pkg::FU_MUL);
            check_val("alu_issue_valid_o", int'(a_idx >= 0), int'(alu_valid));
            check_val("mul_issue_valid_o", int'(m_idx >= 0), int'(mul_valid));
            if (a_idx >= 0) begin
                check_val("alu_issue_opcode_o", int'(m_entry[a_idx].opcode), int'(alu_opcode));
                check_val("alu_issue_dst_o", int'(m_entry[a_idx].dst_tag), int'(alu_dst));
            end
            if (m_idx >= 0) begin
                check_val("mul_issue_opcode_o", int'(m_entry[m_idx].opcode), int'(mul_opcode));
                check_val("mul_issue_dst_o", int'(m_entry[m_idx].dst_tag), int'(mul_dst));
            end
            check_val("free_slots_o", count_free(), int'(free_slots));
            check_val("rs_full_o", int'(m_valid == '1), int'(rs_full));
            // Slots for dispatch come from emptiness before release
            empty = ~m_valid;
            if (flush) begin
                m_valid = '0;
            end else begin
                for (int j = 0; j < DEPTH; j++) begin
                    m_entry[j].src1_rdy = m_entry[j].src1_rdy | cdb_match(m_entry[j].src1_tag);
                    m_entry[j].src2_rdy = m_entry[j].src2_rdy | cdb_match(m_entry[j].src2_tag);
                end
                if (a_idx >= 0)
                    m_valid[a_idx] = 1'b0;
                if (m_idx >= 0)
                    m_valid[m_idx] = 1'b0;
                for (int l = 0; l < 2; l++) begin
                    slot = -1;
                    for (int j = DEPTH - 1; j >= 0; j--)
                        if (empty[j])
                            slot = j;
                    // Lane without a free slot is dropped
                    if (disp_valid[l] && slot >= 0) begin
                        empty[slot]            = 1'b0;
                        m_valid[slot]          = 1'b1;
                        m_entry[slot].opcode   = disp_opcode[l];
                        m_entry[slot].dst_tag  = disp_dst[l];
                        m_entry[slot].src1_tag = disp_src1[l];
                        m_entry[slot].src2_tag = disp_src2[l];
                        m_entry[slot].src1_rdy = disp_src1_rdy[l] | cdb_match(disp_src1[l]);
                        m_entry[slot].src2_rdy = disp_src2_rdy[l] | cdb_match(disp_src2[l]);
                    end
                end
            end
            model_free = count_free();
        end
    end

    // ======================================================================
    // Stimulus helpers
    // ======================================================================
    task automatic idle();
        flush         <= 1'b0;
        disp_valid    <= '0;
        disp_opcode   <= {rs_pkg::OP_ADD, rs_pkg::OP_ADD};
        disp_dst      <= '0;
        disp_src1     <= '0;
        disp_src2     <= '0;
        disp_src1_rdy <= '0;
        disp_src2_rdy <= '0;
        cdb_valid     <= '0;
        cdb_tag       <= '0;
    endtask

    // Next rising edge with all inputs quiet unless overridden
    task automatic next_cycle();
        @(posedge clk);
        idle();
    endtask

    task automatic put_lane(input int l, input rs_pkg::opcode_e op, input rs_pkg::tag_t dst,
                            input rs_pkg::tag_t s1, input logic r1,
                            input rs_pkg::tag_t s2, input logic r2);
        disp_valid[l]    <= 1'b1;
        disp_opcode[l]   <= op;
        disp_dst[l]      <= dst;
        disp_src1[l]     <= s1;
        disp_src1_rdy[l] <= r1;
        disp_src2[l]     <= s2;
        disp_src2_rdy[l] <= r2;
    endtask

    task automatic put_cdb(input int l, input rs_pkg::tag_t t);
        cdb_valid[l] <= 1'b1;
        cdb_tag[l]   <= t;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    task automatic report_test(input string name, input int errs_before);
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name,
                 (err_cnt == errs_before) ? "ok" : "errors seen");
    endtask

    // Run limit
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Simulation ran past %0d cycles without finishing", MAX_CYCLES);
            $display("Test failed");
            $finish;
        end
    end

    // ======================================================================
    // Tests
    // ======================================================================
    initial begin
        int e0;
        int n;
        void'($urandom(32'h268f));
        err_cnt   = 0;
        test_cnt  = 0;
        cycle_cnt = 0;
        idle();
        wait (rst_n);
        idle_cycles(1);

        // Paired ALU and MUL with ready sources
        e0 = err_cnt;
        next_cycle();
        put_lane(0, rs_pkg::OP_ADD, 5'd1, 5'd0, 1'b1, 5'd0, 1'b1);
        put_lane(1, rs_pkg::OP_MUL, 5'd2, 5'd0, 1'b1, 5'd0, 1'b1);
        idle_cycles(3);
        report_test("dual issue", e0);

        // Waiting source and dispatch-time bypass
        e0 = err_cnt;
        next_cycle();
        put_lane(0, rs_pkg::OP_SUB, 5'd3, 5'd10, 1'b0, 5'd0, 1'b1);
        idle_cycles(3);
        put_cdb(0, 5'd10);
        idle_cycles(2);
        put_lane(0, rs_pkg::OP_XOR, 5'd4, 5'd11, 1'b0, 5'd0, 1'b1);
        put_cdb(1, 5'd11);
        idle_cycles(3);
        report_test("cdb wakeup", e0);

        // Fill with not-ready ops and drain
        e0 = err_cnt;
        for (int k = 0; k < 4; k++) begin
            next_cycle();
            put_lane(0, rs_pkg::OP_OR, 5'(2 * k), 5'(20 + 2 * k), 1'b0, 5'd0, 1'b1);
            // Last pair goes in one lane at a time so one free slot shows up
            if (k < 3) begin
                put_lane(1, rs_pkg::OP_MULH, 5'(2 * k + 1), 5'(21 + 2 * k), 1'b0, 5'd0, 1'b1);
            end else begin
                next_cycle();
                put_lane(0, rs_pkg::OP_MULH, 5'(2 * k + 1), 5'(21 + 2 * k), 1'b0, 5'd0, 1'b1);
            end
        end
        idle_cycles(2);
        for (int k = 0; k < 4; k++) begin
            put_cdb(0, 5'(20 + 2 * k));
            put_cdb(1, 5'(21 + 2 * k));
            next_cycle();
        end
        idle_cycles(5);
        report_test("fill and drain", e0);

        // Several ALU ops woken together with a MUL alongside
        e0 = err_cnt;
        next_cycle();
        put_lane(0, rs_pkg::OP_ADD, 5'd7, 5'd30, 1'b0, 5'd0, 1'b1);
        put_lane(1, rs_pkg::OP_AND, 5'd8, 5'd30, 1'b0, 5'd0, 1'b1);
        next_cycle();
        put_lane(0, rs_pkg::OP_MUL, 5'd9, 5'd30, 1'b0, 5'd0, 1'b1);
        put_lane(1, rs_pkg::OP_SLL, 5'd12, 5'd30, 1'b0, 5'd0, 1'b1);
        idle_cycles(2);
        put_cdb(0, 5'd30);
        idle_cycles(6);
        report_test("priority select", e0);

        // Flush with a dispatch in the same cycle
        e0 = err_cnt;
        next_cycle();
        put_lane(0, rs_pkg::OP_ADD, 5'd13, 5'd31, 1'b0, 5'd31, 1'b0);
        put_lane(1, rs_pkg::OP_MUL, 5'd14, 5'd31, 1'b0, 5'd31, 1'b0);
        next_cycle();
        flush <= 1'b1;
        put_lane(0, rs_pkg::OP_SUB, 5'd15, 5'd0, 1'b1, 5'd0, 1'b1);
        idle_cycles(4);
        report_test("flush", e0);

        // Random traffic within the free count
        e0 = err_cnt;
        for (int c = 0; c < 300; c++) begin
            next_cycle();
            n = int'($urandom % 3);
            if (n > model_free)
                n = model_free;
            if ($urandom % 64 == 0)
                flush <= 1'b1;
            for (int l = 0; l < n; l++)
                put_lane(l, rs_pkg::opcode_e'($urandom % 8), rs_pkg::tag_t'($urandom),
                         rs_pkg::tag_t'($urandom), 1'($urandom % 2),
                         rs_pkg::tag_t'($urandom), 1'($urandom % 2));
            for (int l = 0; l < 2; l++)
                if ($urandom % 2 == 1)
                    put_cdb(l, rs_pkg::tag_t'($urandom));
        end
        idle_cycles(4);
        report_test("random traffic", e0);

        $display("%0d tests run, %0d errors", test_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

//--- verilog.f
hdl/rs_pkg.sv
hdl/rs_view_if.sv
hdl/rs_single_entry.sv
hdl/disp_selector.sv
hdl/rs.sv
hdl/fu_issue_select.sv
hdl/issue_merge.sv
hdl/rs_issue_top.sv
verification/tb_clkgen.sv
verification/rs_issue_sva.sv
verification/rs_issue_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the reservation station testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f verilog.f --top-module rs_issue_tb -o sim_rs_issue

./obj_dir/sim_rs_issue > sim.log 2>&1 || true
cat sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
